/* include/tlb_cfg.svh */
// --------------------
// tlb geometry and address widths
// shared by the packages and the rtl
// --------------------

`ifndef TLB_CFG_SVH
`define TLB_CFG_SVH

// set index bits, 16 sets
`define TLB_ORDER 4
// ways per set
`define N_ASSOC 4

// 4k pages
`define PG_BITS 12
`define VADDR_BITS 32
`define PADDR_BITS 32
`define PID_BITS 6

// apb register address
`define APB_ADDR_BITS 4

// derived widths
`define VPN_BITS (`VADDR_BITS - `PG_BITS)
`define PFN_BITS (`PADDR_BITS - `PG_BITS)
`define TAG_BITS (`VPN_BITS - `TLB_ORDER)

`endif

/* verilog/apb_pkg.sv */
// --------------------
// apb bus types
// request, response and slave phase
// --------------------

`include "tlb_cfg.svh"

package apb_pkg;

  // data bus width, strobes are one per byte
  localparam int APB_DATA_BITS = 32;

  // master to slave
  typedef struct packed {
    logic                        psel;
    logic                        penable;
    logic                        pwrite;
    logic [`APB_ADDR_BITS-1:0]   paddr;
    logic [APB_DATA_BITS-1:0]    pwdata;
    logic [APB_DATA_BITS/8-1:0]  pstrb;
  } apb_req_t;

  // slave to master
  typedef struct packed {
    logic                        pready;
    logic [APB_DATA_BITS-1:0]    prdata;
    logic                        pslverr;
  } apb_rsp_t;

  // slave side view of the transfer
  typedef enum logic {
    APB_IDLE   = 1'b0,
    APB_ACCESS = 1'b1
  } apb_phase_e;

endpackage

/* verilog/tlb_pkg.sv */
// --------------------
// tlb types
// entries, sets, commit and lookup requests
// --------------------

`include "tlb_cfg.svh"

package tlb_pkg;

  // one translation
  typedef struct packed {
    logic                   valid;
    logic [`TAG_BITS-1:0]   tag;
    logic [`PID_BITS-1:0]   pid;
    logic [`PFN_BITS-1:0]   pfn;
  } tlb_entry_t;

  // all ways of one set, way 0 in the low bits
  typedef tlb_entry_t [`N_ASSOC-1:0] tlb_set_t;

  // commit opcode
  // write places or overwrites, inval clears a matching way
  typedef enum logic {
    TLB_OP_WRITE = 1'b0,
    TLB_OP_INVAL = 1'b1
  } tlb_op_e;

  // -------------------
  // register slave to store
  // -------------------
  typedef struct packed {
    logic                   valid;
    tlb_op_e                op;
    logic [`TLB_ORDER-1:0]  idx;
    logic [`TAG_BITS-1:0]   tag;
    logic [`PID_BITS-1:0]   pid;
    logic [`PFN_BITS-1:0]   pfn;
  } tlb_wr_req_t;

  // -------------------
  // lookup port
  // -------------------
  typedef struct packed {
    logic                    valid;
    logic [`VADDR_BITS-1:0]  vaddr;
    logic [`PID_BITS-1:0]    pid;
  } tlb_lkp_req_t;

  // paddr is zero on a miss
  typedef struct packed {
    logic                    valid;
    logic                    hit;
    logic [`PADDR_BITS-1:0]  paddr;
  } tlb_lkp_rsp_t;

endpackage

/* verilog/tlb_apb_regs.sv */
// --------------------
// apb register slave for tlb programming
// vpn and pfn staging registers plus a commit counter
// a write to the pfn register issues one commit
// --------------------

`timescale 1ns/1ps

`include "tlb_cfg.svh"

module tlb_apb_regs (
  input  logic                   aclk,
  input  logic                   aresetn,
  input  apb_pkg::apb_req_t      apb_req,
  output apb_pkg::apb_rsp_t      apb_rsp,
  output tlb_pkg::tlb_wr_req_t   wr_req
);

  import apb_pkg::*;
  import tlb_pkg::*;

  // register map, byte addresses
  localparam logic [`APB_ADDR_BITS-1:0] REG_VPN  = 'h0;
  localparam logic [`APB_ADDR_BITS-1:0] REG_PFN  = 'h4;
  localparam logic [`APB_ADDR_BITS-1:0] REG_STAT = 'h8;

  localparam int N_BYTES   = APB_DATA_BITS / 8;
  localparam int CNT_BITS  = 16;
  // valid flag in the vpn register
  localparam int VALID_BIT = 31;

  apb_phase_e                phase_q;
  logic                      acc;
  logic                      dec_err;
  logic [APB_DATA_BITS-1:0]  rdata;
  logic [APB_DATA_BITS-1:0]  vpn_reg;
  logic [APB_DATA_BITS-1:0]  pfn_reg;
  logic [CNT_BITS-1:0]       commit_cnt;
  logic                      commit_pend;
  logic [`VPN_BITS-1:0]      vpn;

  // --------------------
  // phase tracking
  // --------------------
  // setup cycle arms the access phase
  always_ff @(posedge aclk)
  begin
    if (!aresetn)
      phase_q <= APB_IDLE;
    else if (apb_req.psel && !apb_req.penable)
      phase_q <= APB_ACCESS;
    else
      phase_q <= APB_IDLE;
  end

  assign acc = apb_req.psel && apb_req.penable && (phase_q == APB_ACCESS);

  // --------------------
  // read decode and error flag
  // --------------------
  always_comb
  begin
    rdata   = '0;
    dec_err = 1'b0;
    case (apb_req.paddr)
      REG_VPN:  rdata = vpn_reg;
      REG_PFN:  rdata = pfn_reg;
      REG_STAT:
      begin
        rdata   = {{(APB_DATA_BITS-CNT_BITS){1'b0}}, commit_cnt};
        // status is read only
        dec_err = apb_req.pwrite;
      end
      default:  dec_err = 1'b1;
    endcase
  end

  // no wait states
  assign apb_rsp.pready  = 1'b1;
  assign apb_rsp.prdata  = rdata;
  assign apb_rsp.pslverr = acc && dec_err;

  // --------------------
  // staging registers
  // --------------------
  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      vpn_reg     <= '0;
      pfn_reg     <= '0;
      commit_pend <= 1'b0;
    end
    else
    begin
      commit_pend <= 1'b0;
      if (acc && apb_req.pwrite && !dec_err)
      begin
        for (int i = 0; i < N_BYTES; i++)
        begin
          if (apb_req.pstrb[i])
          begin
            if (apb_req.paddr == REG_VPN)
              vpn_reg[i*8 +: 8] <= apb_req.pwdata[i*8 +: 8];
            else
              pfn_reg[i*8 +: 8] <= apb_req.pwdata[i*8 +: 8];
          end
        end
        // any strobed pfn write commits
        if (apb_req.paddr == REG_PFN && |apb_req.pstrb)
          commit_pend <= 1'b1;
      end
    end
  end

  // --------------------
  // commit request
  // --------------------
  assign vpn = vpn_reg[`VPN_BITS-1:0];

  // built one cycle later, from the updated registers
  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      wr_req     <= '0;
      commit_cnt <= '0;
    end
    else
    begin
      wr_req.valid <= commit_pend;
      if (commit_pend)
      begin
        wr_req.op  <= vpn_reg[VALID_BIT] ? TLB_OP_WRITE : TLB_OP_INVAL;
        // low vpn bits pick the set, the rest is the tag
        wr_req.idx <= vpn[`TLB_ORDER-1:0];
        wr_req.tag <= vpn[`VPN_BITS-1:`TLB_ORDER];
        wr_req.pid <= vpn_reg[`VPN_BITS +: `PID_BITS];
        wr_req.pfn <= pfn_reg[`PFN_BITS-1:0];
        commit_cnt <= commit_cnt + 1'b1;
      end
    end
  end

endmodule

/* verilog/tlb_update.sv */
// --------------------
// set associative tlb store
// places commits by hit, first invalid, then round robin victim
// combinational read port for the lookup
// --------------------

`timescale 1ns/1ps

`include "tlb_cfg.svh"

module tlb_update (
  input  logic                   aclk,
  input  logic                   aresetn,
  input  tlb_pkg::tlb_wr_req_t   wr_req,
  input  logic [`TLB_ORDER-1:0]  rd_index,
  output tlb_pkg::tlb_set_t      rd_set
);

  import tlb_pkg::*;

  localparam int N_SETS   = 1 << `TLB_ORDER;
  // way pointer width, assumes more than one way
  localparam int WAY_BITS = $clog2(`N_ASSOC);

  tlb_set_t             sets    [N_SETS];
  logic [WAY_BITS-1:0]  vic_ptr [N_SETS];

  tlb_set_t             cur_set;
  tlb_entry_t           new_entry;
  logic                 hit_any;
  logic                 inv_any;
  logic [WAY_BITS-1:0]  hit_way;
  logic [WAY_BITS-1:0]  inv_way;
  logic [WAY_BITS-1:0]  sel_way;

  // --------------------
  // way selection
  // --------------------
  assign cur_set = sets[wr_req.idx];

  // descending scan so the lowest way wins
  always_comb
  begin
    hit_any = 1'b0;
    inv_any = 1'b0;
    hit_way = '0;
    inv_way = '0;
    for (int w = `N_ASSOC-1; w >= 0; w--)
    begin
      if (cur_set[w].valid && cur_set[w].tag == wr_req.tag && cur_set[w].pid == wr_req.pid)
      begin
        hit_any = 1'b1;
        hit_way = WAY_BITS'(w);
      end
      if (!cur_set[w].valid)
      begin
        inv_any = 1'b1;
        inv_way = WAY_BITS'(w);
      end
    end
    // hit first, then invalid, then victim
    if (hit_any)
      sel_way = hit_way;
    else if (inv_any)
      sel_way = inv_way;
    else
      sel_way = vic_ptr[wr_req.idx];
  end

  assign new_entry = '{valid: 1'b1, tag: wr_req.tag, pid: wr_req.pid, pfn: wr_req.pfn};

  // --------------------
  // array update
  // --------------------
  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      for (int s = 0; s < N_SETS; s++)
      begin
        vic_ptr[s] <= '0;
        for (int w = 0; w < `N_ASSOC; w++)
          sets[s][w].valid <= 1'b0;
      end
    end
    else if (wr_req.valid)
    begin
      if (wr_req.op == TLB_OP_WRITE)
      begin
        sets[wr_req.idx][sel_way] <= new_entry;
        // set full and no match, victim used so move on
        if (!hit_any && !inv_any)
        begin
          if (vic_ptr[wr_req.idx] == WAY_BITS'(`N_ASSOC-1))
            vic_ptr[wr_req.idx] <= '0;
          else
            vic_ptr[wr_req.idx] <= vic_ptr[wr_req.idx] + 1'b1;
        end
      end
      else if (hit_any)
      begin
        // invalidate, no match means no change
        sets[wr_req.idx][hit_way].valid <= 1'b0;
      end
    end
  end

  // read port for the lookup
  assign rd_set = sets[rd_index];

endmodule

/* verilog/tlb_lookup.sv */
// --------------------
// tlb lookup
// parallel tag and pid compare over one set
// registered translation, one cycle latency
// --------------------

`timescale 1ns/1ps

`include "tlb_cfg.svh"

module tlb_lookup (
  input  logic                   aclk,
  input  logic                   aresetn,
  input  tlb_pkg::tlb_lkp_req_t  lkp_req,
  input  tlb_pkg::tlb_set_t      rd_set,
  output logic [`TLB_ORDER-1:0]  rd_index,
  output tlb_pkg::tlb_lkp_rsp_t  lkp_rsp
);

  import tlb_pkg::*;

  logic [`PG_BITS-1:0]     offset;
  logic [`TAG_BITS-1:0]    tag;
  logic                    hit;
  logic [`PFN_BITS-1:0]    hit_pfn;
  logic [`PADDR_BITS-1:0]  paddr;

  // --------------------
  // vaddr split
  // --------------------
  // offset | index | tag, from the low end
  assign offset   = lkp_req.vaddr[`PG_BITS-1:0];
  assign rd_index = lkp_req.vaddr[`PG_BITS +: `TLB_ORDER];
  assign tag      = lkp_req.vaddr[`VADDR_BITS-1 -: `TAG_BITS];

  // --------------------
  // compare all ways
  // --------------------
  // at most one way matches, store dedups on write
  always_comb
  begin
    hit     = 1'b0;
    hit_pfn = '0;
    for (int w = 0; w < `N_ASSOC; w++)
    begin
      if (rd_set[w].valid && rd_set[w].tag == tag && rd_set[w].pid == lkp_req.pid)
      begin
        hit     = 1'b1;
        hit_pfn = rd_set[w].pfn;
      end
    end
  end

  // zero address on a miss
  assign paddr = hit ? {hit_pfn, offset} : '0;

  // response register
  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      lkp_rsp <= '0;
    end
    else
    begin
      lkp_rsp.valid <= lkp_req.valid;
      lkp_rsp.hit   <= hit;
      lkp_rsp.paddr <= paddr;
    end
  end

endmodule

/* verilog/tlb_ctrl_top.sv */
// --------------------
// tlb control top
// apb slave, entry store and lookup
// --------------------

`timescale 1ns/1ps

`include "tlb_cfg.svh"

module tlb_ctrl_top (
  input  logic                   aclk,
  input  logic                   aresetn,
  input  apb_pkg::apb_req_t      apb_req,
  output apb_pkg::apb_rsp_t      apb_rsp,
  input  tlb_pkg::tlb_lkp_req_t  lkp_req,
  output tlb_pkg::tlb_lkp_rsp_t  lkp_rsp
);

  import tlb_pkg::*;

  // commit path
  tlb_wr_req_t            wr_req;
  // read port, lookup to store
  logic [`TLB_ORDER-1:0]  rd_index;
  tlb_set_t               rd_set;

  // register slave, decodes apb into commits
  tlb_apb_regs u_tlb_apb_regs (
    .aclk     (aclk),
    .aresetn  (aresetn),
    .apb_req  (apb_req),
    .apb_rsp  (apb_rsp),
    .wr_req   (wr_req)
  );

  // entry array and replacement
  tlb_update u_tlb_update (
    .aclk     (aclk),
    .aresetn  (aresetn),
    .wr_req   (wr_req),
    .rd_index (rd_index),
    .rd_set   (rd_set)
  );

  // translation
  tlb_lookup u_tlb_lookup (
    .aclk     (aclk),
    .aresetn  (aresetn),
    .lkp_req  (lkp_req),
    .rd_set   (rd_set),
    .rd_index (rd_index),
    .lkp_rsp  (lkp_rsp)
  );

endmodule

/* verif/tlb_ctrl_sva.sv */
// --------------------
// apb and lookup protocol assertions
// bound to the tlb control top
// --------------------

`timescale 1ns/1ps

module tlb_ctrl_sva (
  input logic                   aclk,
  input logic                   aresetn,
  input apb_pkg::apb_req_t      apb_req,
  input apb_pkg::apb_rsp_t      apb_rsp,
  input tlb_pkg::tlb_lkp_req_t  lkp_req,
  input tlb_pkg::tlb_lkp_rsp_t  lkp_rsp
);

  // access phase only after a setup cycle with psel
  penable_after_psel: assert property (@(posedge aclk) disable iff (!aresetn)
    $rose(apb_req.penable) |-> $past(apb_req.psel))
    else $error("penable rose without psel in the previous cycle");

  // zero wait states
  pready_in_access: assert property (@(posedge aclk) disable iff (!aresetn)
    apb_req.psel && apb_req.penable |-> apb_rsp.pready)
    else $error("pready low in an access phase");

  // fixed one cycle lookup latency
  lkp_valid_follows: assert property (@(posedge aclk) disable iff (!aresetn)
    lkp_req.valid |=> lkp_rsp.valid)
    else $error("lookup response missing one cycle after a request");

  lkp_valid_only_after_req: assert property (@(posedge aclk) disable iff (!aresetn)
    !lkp_req.valid |=> !lkp_rsp.valid)
    else $error("lookup response valid without a request");

  // error flag lives in the access phase only
  pslverr_in_access: assert property (@(posedge aclk) disable iff (!aresetn)
    apb_rsp.pslverr |-> apb_req.psel && apb_req.penable)
    else $error("pslverr set outside an access phase");

endmodule

bind tlb_ctrl_top tlb_ctrl_sva u_tlb_ctrl_sva (
  .aclk    (aclk),
  .aresetn (aresetn),
  .apb_req (apb_req),
  .apb_rsp (apb_rsp),
  .lkp_req (lkp_req),
  .lkp_rsp (lkp_rsp)
);

/* verif/tlb_ctrl_tb.sv */
// --------------------
// tlb control testbench
// table driven apb programming and lookups
// expected results from a reference tlb model
// --------------------

`timescale 1ns/1ps

`include "tlb_cfg.svh"

module tlb_ctrl_tb;

  import apb_pkg::*;
  import tlb_pkg::*;

  localparam int PERIOD = 8;
  localparam int N_SETS = 1 << `TLB_ORDER;

  // row operation
  typedef enum logic [2:0] {PROG, INVAL, LKP, WR, RD} row_op_e;

  // one row of stimulus and expected values
  typedef struct packed {
    row_op_e                    op;
    logic [`VPN_BITS-1:0]       vpn;
    logic [`PID_BITS-1:0]       pid;
    logic [31:0]                data;
    logic [3:0]                 strb;
    logic [`APB_ADDR_BITS-1:0]  addr;
    logic                       exp_hit;
    logic [31:0]                exp_data;
    logic                       exp_err;
  } row_t;

  logic          aclk = 1'b0;
  logic          aresetn;
  apb_req_t      apb_req;
  apb_rsp_t      apb_rsp;
  tlb_lkp_req_t  lkp_req;
  tlb_lkp_rsp_t  lkp_rsp;

  row_t          tbl [$];
  int            n_rows = 0;
  int            errors = 0;
  int            checks = 0;

  // --------------------
  // reference model state
  // --------------------
  tlb_entry_t    ref_tlb [N_SETS][`N_ASSOC];
  int            ref_vic [N_SETS];
  // shadow copies of the vpn and pfn registers
  logic [31:0]   vpn_shadow;
  logic [31:0]   pfn_shadow;

  tlb_ctrl_top u_tlb_ctrl_top (
    .aclk    (aclk),
    .aresetn (aresetn),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp),
    .lkp_req (lkp_req),
    .lkp_rsp (lkp_rsp)
  );

  always #(PERIOD/2) aclk = ~aclk;

  function automatic void push_row(input row_op_e op, input logic [`VPN_BITS-1:0] vpn,
                                   input logic [`PID_BITS-1:0] pid, input logic [31:0] data,
                                   input logic [3:0] strb, input logic [3:0] addr,
                                   input logic exp_hit, input logic [31:0] exp_data,
                                   input logic exp_err);
    row_t r;
    r = '{op, vpn, pid, data, strb, addr, exp_hit, exp_data, exp_err};
    tbl.push_back(r);
  endfunction

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] got);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("Fail %s expected 0x%h got 0x%h", name, exp, got);
    end
  endtask

  function automatic logic entry_matches(input tlb_entry_t e, input logic [`TAG_BITS-1:0] tag,
                                         input logic [`PID_BITS-1:0] pid);
    return e.valid && e.tag == tag && e.pid == pid;
  endfunction

  // hit first, then lowest invalid way, then round robin victim
  function automatic void update_model(input logic [31:0] vreg, input logic [31:0] preg);
    int                    s;
    int                    way;
    logic [`TAG_BITS-1:0]  tag;
    logic [`PID_BITS-1:0]  pid;
    s   = int'(vreg[`TLB_ORDER-1:0]);
    tag = vreg[`VPN_BITS-1:`TLB_ORDER];
    pid = vreg[`VPN_BITS +: `PID_BITS];
    way = -1;
    for (int w = 0; w < `N_ASSOC; w++)
      if (way < 0 && entry_matches(ref_tlb[s][w], tag, pid))
        way = w;
    // bit 31 is the entry valid flag
    if (vreg[31])
    begin
      for (int w = 0; w < `N_ASSOC; w++)
        if (way < 0 && !ref_tlb[s][w].valid)
          way = w;
      if (way < 0)
      begin
        way        = ref_vic[s];
        ref_vic[s] = (ref_vic[s] + 1) % `N_ASSOC;
      end
      ref_tlb[s][way] = '{valid: 1'b1, tag: tag, pid: pid, pfn: preg[`PFN_BITS-1:0]};
    end
    else if (way >= 0)
      ref_tlb[s][way].valid = 1'b0;
  endfunction

  function automatic void find_entry(input logic [`VPN_BITS-1:0] vpn,
                                     input logic [`PID_BITS-1:0] pid,
                                     output logic hit, output logic [`PFN_BITS-1:0] pfn);
    int s;
    s   = int'(vpn[`TLB_ORDER-1:0]);
    hit = 1'b0;
    pfn = '0;
    for (int w = 0; w < `N_ASSOC; w++)
      if (entry_matches(ref_tlb[s][w], vpn[`VPN_BITS-1:`TLB_ORDER], pid))
      begin
        hit = 1'b1;
        pfn = ref_tlb[s][w].pfn;
      end
  endfunction

  // --------------------
  // apb transfers
  // --------------------
  // setup phase then access phase until pready
  task automatic transfer(input logic wr, input logic [3:0] addr, input logic [31:0] data,
                          input logic [3:0] strb, output logic [31:0] rdata,
                          output logic err);
    @(negedge aclk);
    apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr,
                pwdata: data, pstrb: strb};
    @(negedge aclk);
    apb_req.penable = 1'b1;
    // sample mid cycle before the access edge
    #(PERIOD/4);
    while (!apb_rsp.pready)
    begin
      @(negedge aclk);
      #(PERIOD/4);
    end
    rdata = apb_rsp.prdata;
    err   = apb_rsp.pslverr;
    @(negedge aclk);
    apb_req = '0;
  endtask

  // write and merge into the shadow copies
  // a strobed pfn write also commits
  task automatic write_reg(input logic [3:0] addr, input logic [31:0] data,
                           input logic [3:0] strb, output logic err);
    logic [31:0] rdata;
    transfer(1'b1, addr, data, strb, rdata, err);
    for (int i = 0; i < 4; i++)
    begin
      if (strb[i] && addr == 4'h0)
        vpn_shadow[i*8 +: 8] = data[i*8 +: 8];
      if (strb[i] && addr == 4'h4)
        pfn_shadow[i*8 +: 8] = data[i*8 +: 8];
    end
    if (addr == 4'h4 && |strb)
      update_model(vpn_shadow, pfn_shadow);
  endtask

  task automatic run_row(input row_t r);
    logic [31:0]           rdata;
    logic [31:0]           rnd;
    logic                  err;
    logic [`PG_BITS-1:0]   off;
    logic                  m_hit;
    logic [`PFN_BITS-1:0]  m_pfn;
    logic [31:0]           exp_paddr;
    case (r.op)
      PROG, INVAL:
      begin
        // valid bit set for program and clear for invalidate
        write_reg(4'h0, {r.op == PROG, 5'b0, r.pid, r.vpn}, 4'hF, err);
        write_reg(4'h4, r.data, 4'hF, err);
        // entry lands two edges after the access edge
        repeat (2) @(negedge aclk);
      end
      WR:
      begin
        write_reg(r.addr, r.data, r.strb, err);
        compare("pslverr", 32'(r.exp_err), 32'(err));
      end
      RD:
      begin
        transfer(1'b0, r.addr, '0, '0, rdata, err);
        compare("prdata", r.exp_data, rdata);
        compare("pslverr", 32'(r.exp_err), 32'(err));
      end
      LKP:
      begin
        rnd = $urandom;
        off = rnd[`PG_BITS-1:0];
        find_entry(r.vpn, r.pid, m_hit, m_pfn);
        if (m_hit !== r.exp_hit)
        begin
          errors++;
          $display("reference model and table disagree on a hit for vpn 0x%h pid 0x%h",
                   r.vpn, r.pid);
        end
        exp_paddr = m_hit ? {m_pfn, off} : '0;
        @(negedge aclk);
        lkp_req = '{valid: 1'b1, vaddr: {r.vpn, off}, pid: r.pid};
        @(negedge aclk);
        lkp_req = '0;
        // registered response one cycle after the request
        compare("lkp_rsp.valid", 32'd1, 32'(lkp_rsp.valid));
        compare("lkp_rsp.hit", 32'(r.exp_hit), 32'(lkp_rsp.hit));
        compare("lkp_rsp.paddr", exp_paddr, lkp_rsp.paddr);
      end
    endcase
  endtask

  // --------------------
  // stimulus table
  // --------------------
  function automatic void build_table();
    //       op     vpn        pid    data                    strb  addr  hit   exp_data  err
    // byte strobes merge and pfn writes commit
    push_row(WR,    20'h00000, 6'h00, 32'h8123_4567,         4'hF, 4'h0, 1'b0, 32'h0, 1'b0);
    push_row(WR,    20'h00000, 6'h00, 32'hAABB_CCDD,         4'h5, 4'h0, 1'b0, 32'h0, 1'b0);
    push_row(RD,    20'h00000, 6'h00, 32'h0,                 4'h0, 4'h0, 1'b0,
             32'h81BB_45DD, 1'b0);
    push_row(WR,    20'h00000, 6'h00, 32'h0001_2345,         4'hF, 4'h4, 1'b0, 32'h0, 1'b0);
    push_row(WR,    20'h00000, 6'h00, 32'hFFFF_FFFF,         4'h2, 4'h4, 1'b0, 32'h0, 1'b0);
    push_row(RD,    20'h00000, 6'h00, 32'h0,                 4'h0, 4'h4, 1'b0,
             32'h0001_FF45, 1'b0);
    // a write without strobes changes nothing and commits nothing
    push_row(WR,    20'h00000, 6'h00, 32'h1234_5678,         4'h0, 4'h4, 1'b0, 32'h0, 1'b0);
    push_row(RD,    20'h00000, 6'h00, 32'h0,                 4'h0, 4'h4, 1'b0,
             32'h0001_FF45, 1'b0);
    push_row(RD,    20'h00000, 6'h00, 32'h0,                 4'h0, 4'h8, 1'b0, 32'h2, 1'b0);
    // status is read only and 0xc is unmapped
    push_row(WR,    20'h00000, 6'h00, 32'h1,                 4'hF, 4'h8, 1'b0, 32'h0, 1'b1);
    push_row(RD,    20'h00000, 6'h00, 32'h0,                 4'h0, 4'hC, 1'b0, 32'h0, 1'b1);
    push_row(WR,    20'h00000, 6'h00, 32'h5,                 4'hF, 4'hC, 1'b0, 32'h0, 1'b1);
    push_row(RD,    20'h00000, 6'h00, 32'h0,                 4'h0, 4'h8, 1'b0, 32'h2, 1'b0);
    push_row(LKP,   20'hB45DD, 6'h1B, 32'h0,                 4'h0, 4'h0, 1'b1, 32'h0, 1'b0);
    // translation and pid isolation
    push_row(PROG,  20'h12345, 6'h03, 32'hABCDE,             4'hF, 4'h0, 1'b0, 32'h0, 1'b0);
    push_row(LKP,   20'h12345, 6'h03, 32'h0,                 4'h0, 4'h0, 1'b1, 32'h0, 1'b0);
    push_row(LKP,   20'h12345, 6'h04, 32'h0,                 4'h0, 4'h0, 1'b0, 32'h0, 1'b0);
    push_row(LKP,   20'h54321, 6'h03, 32'h0,                 4'h0, 4'h0, 1'b0, 32'h0, 1'b0);
    // five vpns in set 6 where the fifth evicts way 0
    push_row(PROG,  20'h00016, 6'h01, $urandom & 32'hF_FFFF, 4'hF, 4'h0, 1'b0, 32'h0, 1'b0);
    push_row(PROG,  20'h00026, 6'h01, $urandom & 32'hF_FFFF, 4'hF, 4'h0, 1'b0, 32'h0, 1'b0);
    push_row(PROG,  20'h00036, 6'h01, $urandom & 32'hF_FFFF, 4'hF, 4'h0, 1'b0, 32'h0, 1'b0);
    push_row(PROG,  20'h00046, 6'h01, $urandom & 32'hF_FFFF, 4'hF, 4'h0, 1'b0, 32'h0, 1'b0);
    push_row(PROG,  20'h00056, 6'h01, $urandom & 32'hF_FFFF, 4'hF, 4'h0, 1'b0, 32'h0, 1'b0);
    push_row(LKP,   20'h00016, 6'h01, 32'h0,                 4'h0, 4'h0, 1'b0, 32'h0, 1'b0);
    push_row(LKP,   20'h00026, 6'h01, 32'h0,                 4'h0, 4'h0, 1'b1, 32'h0, 1'b0);
    push_row(LKP,   20'h00036, 6'h01, 32'h0,                 4'h0, 4'h0, 1'b1, 32'h0, 1'b0);
    push_row(LKP,   20'h00046, 6'h01, 32'h0,                 4'h0, 4'h0, 1'b1, 32'h0, 1'b0);
    push_row(LKP,   20'h00056, 6'h01, 32'h0,                 4'h0, 4'h0, 1'b1, 32'h0, 1'b0);
    // overwrite in place with nothing evicted
    push_row(PROG,  20'h00036, 6'h01, 32'h77777,             4'hF, 4'h0, 1'b0, 32'h0, 1'b0);
    push_row(LKP,   20'h00036, 6'h01, 32'h0,                 4'h0, 4'h0, 1'b1, 32'h0, 1'b0);
    push_row(LKP,   20'h00026, 6'h01, 32'h0,                 4'h0, 4'h0, 1'b1, 32'h0, 1'b0);
    push_row(LKP,   20'h00046, 6'h01, 32'h0,                 4'h0, 4'h0, 1'b1, 32'h0, 1'b0);
    push_row(LKP,   20'h00056, 6'h01, 32'h0,                 4'h0, 4'h0, 1'b1, 32'h0, 1'b0);
    // invalidate in set 9 while the other pid survives
    push_row(PROG,  20'h00109, 6'h01, $urandom & 32'hF_FFFF, 4'hF, 4'h0, 1'b0, 32'h0, 1'b0);
    push_row(PROG,  20'h00109, 6'h02, $urandom & 32'hF_FFFF, 4'hF, 4'h0, 1'b0, 32'h0, 1'b0);
    push_row(PROG,  20'h00209, 6'h01, $urandom & 32'hF_FFFF, 4'hF, 4'h0, 1'b0, 32'h0, 1'b0);
    push_row(INVAL, 20'h00109, 6'h01, 32'h0,                 4'hF, 4'h0, 1'b0, 32'h0, 1'b0);
    push_row(LKP,   20'h00109, 6'h01, 32'h0,                 4'h0, 4'h0, 1'b0, 32'h0, 1'b0);
    push_row(LKP,   20'h00109, 6'h02, 32'h0,                 4'h0, 4'h0, 1'b1, 32'h0, 1'b0);
    push_row(LKP,   20'h00209, 6'h01, 32'h0,                 4'h0, 4'h0, 1'b1, 32'h0, 1'b0);
    // thirteen commits in total
    push_row(RD,    20'h00000, 6'h00, 32'h0,                 4'h0, 4'h8, 1'b0, 32'hD, 1'b0);
  endfunction

  // --------------------
  // main sequence
  // --------------------
  initial
  begin
    // one seed for offsets and filler pfns
    void'($urandom(62));
    aresetn    = 1'b0;
    apb_req    = '0;
    lkp_req    = '0;
    vpn_shadow = '0;
    pfn_shadow = '0;
    for (int s = 0; s < N_SETS; s++)
    begin
      ref_vic[s] = 0;
      for (int w = 0; w < `N_ASSOC; w++)
        ref_tlb[s][w] = '0;
    end
    build_table();
    n_rows = tbl.size();
    repeat (10) @(negedge aclk);
    aresetn = 1'b1;
    compare("lkp_rsp.valid", 32'd0, 32'(lkp_rsp.valid));
    foreach (tbl[i])
      run_row(tbl[i]);
    repeat (2) @(negedge aclk);
    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

  // watchdog allows 20 cycles per row plus reset
  initial
  begin
    wait (n_rows > 0);
    #((n_rows * 20 + 10) * PERIOD);
    $display("timeout: %0d table rows did not finish in time", n_rows);
    $display("Test FAILED");
    $finish;
  end

endmodule

/* tlb_ctrl.f */
+incdir+include
verilog/apb_pkg.sv
verilog/tlb_pkg.sv
verilog/tlb_apb_regs.sv
verilog/tlb_update.sv
verilog/tlb_lookup.sv
verilog/tlb_ctrl_top.sv
verif/tlb_ctrl_sva.sv
verif/tlb_ctrl_tb.sv

/* Makefile */
# Verilator build and run of the tlb control testbench
# every variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tlb_ctrl_tb
FILELIST  ?= tlb_ctrl.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Test OK

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard include/*.svh)
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source, a header or the file list changes
$(SIM): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# the pass line in the log decides the status
run: $(SIM)
	$(SIM) 2>&1 | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
